//--- fir_pkg.sv
`default_nettype none

package fir_pkg;

	//**************************************************
	// filter geometry
	//**************************************************

	// taps, must be a power of two
	localparam int FIR_TAPS = 32;
	// address width of both memories
	localparam int FIR_PTR = $clog2(FIR_TAPS);
	localparam logic [FIR_PTR-1:0] LAST_TAP = FIR_PTR'(FIR_TAPS - 1);

	//**************************************************
	// arithmetic widths
	//**************************************************

	localparam int SAMPLE_W = 16;
	localparam int COEFF_W = 16;
	// q15 coefficients
	localparam int COEFF_FRAC = 15;
	localparam int PROD_W = SAMPLE_W + COEFF_W;
	// guard bits so FIR_TAPS full-scale products never overflow
	localparam int ACC_W = PROD_W + FIR_PTR;
	// accumulator after dropping the fraction bits
	localparam int SCALED_W = ACC_W - COEFF_FRAC;
	localparam logic signed [SCALED_W-1:0] SAMPLE_MAX = SCALED_W'((2 ** (SAMPLE_W - 1)) - 1);
	localparam logic signed [SCALED_W-1:0] SAMPLE_MIN = -SCALED_W'(2 ** (SAMPLE_W - 1));

	//**************************************************
	// control state machine, one-hot
	//**************************************************

	localparam int ST_CLEAR = 0;
	localparam int ST_IDLE = 1;
	localparam int ST_MULTIPLY_1ST = 2;
	localparam int ST_MULTIPLY = 3;
	localparam int ST_DRAIN = 4;
	localparam int ST_OUTPUT = 5;
	localparam int ST_N = 6;

	typedef logic [ST_N-1:0] fsm_state_t;

	localparam fsm_state_t S_CLEAR = fsm_state_t'(1 << ST_CLEAR);
	localparam fsm_state_t S_IDLE = fsm_state_t'(1 << ST_IDLE);
	localparam fsm_state_t S_MULTIPLY_1ST = fsm_state_t'(1 << ST_MULTIPLY_1ST);
	localparam fsm_state_t S_MULTIPLY = fsm_state_t'(1 << ST_MULTIPLY);
	localparam fsm_state_t S_DRAIN = fsm_state_t'(1 << ST_DRAIN);
	localparam fsm_state_t S_OUTPUT = fsm_state_t'(1 << ST_OUTPUT);

	//**************************************************
	// payload types
	//**************************************************

	// left in the upper half, right in the lower half
	typedef struct packed {
		logic signed [SAMPLE_W-1:0] left;
		logic signed [SAMPLE_W-1:0] right;
	} stereo_sample_t;

	typedef logic signed [COEFF_W-1:0] coeff_t;

	typedef struct packed {
		logic signed [ACC_W-1:0] left;
		logic signed [ACC_W-1:0] right;
	} stereo_acc_t;

	// host write into the coefficient table
	typedef struct packed {
		logic valid;
		logic [FIR_PTR-1:0] addr;
		coeff_t data;
	} coeff_wr_t;

	// load starts a sum, enable adds, finish scales and latches
	typedef struct packed {
		logic load;
		logic enable;
		logic finish;
	} mac_ctl_t;

endpackage

`default_nettype wire

//--- fir_ram.sv
`default_nettype none

// circular storage shared by history and coefficient tables
module fir_ram
	import fir_pkg::*;
#(
	parameter type data_t = logic [15:0]
)
(
	input wire clk,
	// write side
	input wire wren,
	input wire [FIR_PTR-1:0] wrptr,
	input wire data_t wrdata,
	// read side, one cycle latency
	input wire rden,
	input wire [FIR_PTR-1:0] rdptr,
	output data_t rddata
);

	//**************************************************
	// storage array
	//**************************************************

	// contents come from the clear pass or the host
	data_t mem [FIR_TAPS];

	// single write port
	always_ff @(posedge clk)
	begin
		if (wren)
		begin
			mem[wrptr] <= wrdata;
		end
	end

	//**************************************************
	// registered read port
	//**************************************************

	// data holds while rden is low
	always_ff @(posedge clk)
	begin
		if (rden)
		begin
			rddata <= mem[rdptr];
		end
	end

endmodule

`default_nettype wire

//--- filter_stm.sv
`default_nettype none

module filter_stm
	import fir_pkg::*;
(
	input wire clk,
	input wire rstb,
	// sample intake
	input wire stereo_sample_t aud_in,
	input wire aud_in_rts,
	output logic aud_in_rtr,
	// result handshake
	output logic aud_out_rts,
	input wire aud_out_rtr,
	// history write side
	output logic hist_wren,
	output logic [FIR_PTR-1:0] hist_wrptr,
	output stereo_sample_t hist_wrdata,
	// read side of both memories
	output logic rden,
	output logic [FIR_PTR-1:0] hist_rdptr,
	output logic [FIR_PTR-1:0] coeff_rdptr,
	// mac control, lined up with ram read data
	output mac_ctl_t mac_ctl
);

	//**************************************************
	// state and next-state registers
	//**************************************************

	fsm_state_t state, state_nxt;
	// newest sample slot, also the clear counter
	logic [FIR_PTR-1:0] wr_ptr, wr_ptr_nxt;
	// next tap to issue
	logic [FIR_PTR-1:0] tap_cnt, tap_cnt_nxt;
	logic aud_in_rtr_nxt;
	logic aud_out_rts_nxt;
	logic hist_wren_nxt;
	logic [FIR_PTR-1:0] hist_wrptr_nxt;
	logic rden_nxt;
	logic [FIR_PTR-1:0] hist_rdptr_nxt;
	logic [FIR_PTR-1:0] coeff_rdptr_nxt;
	// mac control at read issue, before the ram delay
	mac_ctl_t ctl_pre, ctl_pre_nxt;
	logic xfc_in;
	logic xfc_out;

	// handshake completes on this edge
	assign xfc_in = aud_in_rtr & aud_in_rts;
	assign xfc_out = aud_out_rts & aud_out_rtr;

	//**************************************************
	// next-state logic
	//**************************************************

	always_comb
	begin
		state_nxt = state;
		wr_ptr_nxt = wr_ptr;
		tap_cnt_nxt = tap_cnt;
		aud_in_rtr_nxt = aud_in_rtr;
		aud_out_rts_nxt = aud_out_rts;
		hist_wrptr_nxt = hist_wrptr;
		hist_rdptr_nxt = hist_rdptr;
		coeff_rdptr_nxt = coeff_rdptr;
		// strobes default low
		hist_wren_nxt = 1'b0;
		rden_nxt = 1'b0;
		ctl_pre_nxt = '0;

		case (1'b1)
			// zero the whole history once after reset
			state[ST_CLEAR]:
			begin
				hist_wren_nxt = 1'b1;
				hist_wrptr_nxt = wr_ptr;
				wr_ptr_nxt = wr_ptr + FIR_PTR'(1);
				// pointer wraps back to slot 0
				if (wr_ptr == LAST_TAP)
				begin
					state_nxt = S_IDLE;
				end
			end

			// wait for a sample
			state[ST_IDLE]:
			begin
				if (xfc_in)
				begin
					aud_in_rtr_nxt = 1'b0;
					hist_wren_nxt = 1'b1;
					hist_wrptr_nxt = wr_ptr;
					state_nxt = S_MULTIPLY_1ST;
				end
				else
				begin
					aud_in_rtr_nxt = 1'b1;
				end
			end

			// tap 0, newest sample, starts a fresh sum
			state[ST_MULTIPLY_1ST]:
			begin
				rden_nxt = 1'b1;
				hist_rdptr_nxt = wr_ptr;
				coeff_rdptr_nxt = '0;
				ctl_pre_nxt.load = 1'b1;
				tap_cnt_nxt = FIR_PTR'(1);
				state_nxt = S_MULTIPLY;
			end

			// taps 1 to FIR_TAPS-1, walking back through history
			state[ST_MULTIPLY]:
			begin
				rden_nxt = 1'b1;
				hist_rdptr_nxt = wr_ptr - tap_cnt;
				coeff_rdptr_nxt = tap_cnt;
				ctl_pre_nxt.enable = 1'b1;
				tap_cnt_nxt = tap_cnt + FIR_PTR'(1);
				if (tap_cnt == LAST_TAP)
				begin
					state_nxt = S_DRAIN;
				end
			end

			// last product still in flight, then scale
			state[ST_DRAIN]:
			begin
				ctl_pre_nxt.finish = 1'b1;
				state_nxt = S_OUTPUT;
			end

			// offer result once the mac has latched it
			state[ST_OUTPUT]:
			begin
				if (mac_ctl.finish)
				begin
					aud_out_rts_nxt = 1'b1;
				end
				if (xfc_out)
				begin
					aud_out_rts_nxt = 1'b0;
					wr_ptr_nxt = wr_ptr + FIR_PTR'(1);
					state_nxt = S_IDLE;
				end
			end

			default:
			begin
				state_nxt = S_CLEAR;
			end
		endcase
	end

	//**************************************************
	// registers
	//**************************************************

	always_ff @(posedge clk or negedge rstb)
	begin
		if (!rstb)
		begin
			state <= S_CLEAR;
			wr_ptr <= '0;
			tap_cnt <= '0;
			aud_in_rtr <= 1'b0;
			aud_out_rts <= 1'b0;
			hist_wren <= 1'b0;
			hist_wrptr <= '0;
			rden <= 1'b0;
			hist_rdptr <= '0;
			coeff_rdptr <= '0;
			ctl_pre <= '0;
			mac_ctl <= '0;
		end
		else
		begin
			state <= state_nxt;
			wr_ptr <= wr_ptr_nxt;
			tap_cnt <= tap_cnt_nxt;
			aud_in_rtr <= aud_in_rtr_nxt;
			aud_out_rts <= aud_out_rts_nxt;
			hist_wren <= hist_wren_nxt;
			hist_wrptr <= hist_wrptr_nxt;
			rden <= rden_nxt;
			hist_rdptr <= hist_rdptr_nxt;
			coeff_rdptr <= coeff_rdptr_nxt;
			ctl_pre <= ctl_pre_nxt;
			// one cycle later, matching ram read latency
			mac_ctl <= ctl_pre;
		end
	end

	// write data, zero while clearing
	always_ff @(posedge clk)
	begin
		if (hist_wren_nxt)
		begin
			if (state[ST_CLEAR])
			begin
				hist_wrdata <= '0;
			end
			else
			begin
				hist_wrdata <= aud_in;
			end
		end
	end

endmodule

`default_nettype wire

//--- stereo_mac.sv
`default_nettype none

module stereo_mac
	import fir_pkg::*;
(
	input wire clk,
	input wire rstb,
	// history word and coefficient, straight from the rams
	input wire stereo_sample_t sample,
	input wire coeff_t coeff,
	input wire mac_ctl_t mac_ctl,
	// held until the next finish
	output stereo_sample_t result
);

	//**************************************************
	// scaling with saturation
	//**************************************************

	// drop q15 fraction, floor, then clamp to 16 bits
	function automatic logic signed [SAMPLE_W-1:0] scale_sat(
		input logic signed [ACC_W-1:0] sum
	);
		logic signed [SCALED_W-1:0] scaled;

		// upper bits only, same as an arithmetic shift
		scaled = sum[ACC_W-1:COEFF_FRAC];
		if (scaled > SAMPLE_MAX)
		begin
			return SAMPLE_MAX[SAMPLE_W-1:0];
		end
		else if (scaled < SAMPLE_MIN)
		begin
			return SAMPLE_MIN[SAMPLE_W-1:0];
		end
		return scaled[SAMPLE_W-1:0];
	endfunction

	//**************************************************
	// products
	//**************************************************

	logic signed [PROD_W-1:0] prod_left;
	logic signed [PROD_W-1:0] prod_right;
	stereo_acc_t acc;

	// one coefficient shared by both channels
	assign prod_left = sample.left * coeff;
	assign prod_right = sample.right * coeff;

	//**************************************************
	// accumulators
	//**************************************************

	// load replaces, enable adds, otherwise hold
	always_ff @(posedge clk)
	begin
		if (mac_ctl.load)
		begin
			acc.left <= ACC_W'(prod_left);
			acc.right <= ACC_W'(prod_right);
		end
		else if (mac_ctl.enable)
		begin
			acc.left <= acc.left + ACC_W'(prod_left);
			acc.right <= acc.right + ACC_W'(prod_right);
		end
	end

	//**************************************************
	// output register
	//**************************************************

	always_ff @(posedge clk or negedge rstb)
	begin
		if (!rstb)
		begin
			result <= '0;
		end
		else if (mac_ctl.finish)
		begin
			result.left <= scale_sat(acc.left);
			result.right <= scale_sat(acc.right);
		end
	end

endmodule

`default_nettype wire

//--- audio_fir.sv
`default_nettype none

module audio_fir
	import fir_pkg::*;
(
	input wire clk,
	input wire rstb,
	// sample in
	input wire stereo_sample_t aud_in,
	input wire aud_in_rts,
	output logic aud_in_rtr,
	// filtered sample out
	output stereo_sample_t aud_out,
	output logic aud_out_rts,
	input wire aud_out_rtr,
	// host coefficient writes
	input wire coeff_wr_t coeff_wr
);

	//**************************************************
	// internal nets
	//**************************************************

	logic hist_wren;
	logic [FIR_PTR-1:0] hist_wrptr;
	stereo_sample_t hist_wrdata;
	// shared read strobe for both tables
	logic rden;
	logic [FIR_PTR-1:0] hist_rdptr;
	logic [FIR_PTR-1:0] coeff_rdptr;
	stereo_sample_t hist_rddata;
	coeff_t coeff_rddata;
	mac_ctl_t mac_ctl;

	// control
	filter_stm filter_stm_inst (
		.clk (clk),
		.rstb (rstb),
		.aud_in (aud_in),
		.aud_in_rts (aud_in_rts),
		.aud_in_rtr (aud_in_rtr),
		.aud_out_rts (aud_out_rts),
		.aud_out_rtr (aud_out_rtr),
		.hist_wren (hist_wren),
		.hist_wrptr (hist_wrptr),
		.hist_wrdata (hist_wrdata),
		.rden (rden),
		.hist_rdptr (hist_rdptr),
		.coeff_rdptr (coeff_rdptr),
		.mac_ctl (mac_ctl)
	);

	// circular sample history
	fir_ram #(.data_t(stereo_sample_t)) hist_ram (
		.clk (clk),
		.wren (hist_wren),
		.wrptr (hist_wrptr),
		.wrdata (hist_wrdata),
		.rden (rden),
		.rdptr (hist_rdptr),
		.rddata (hist_rddata)
	);

	// coefficient table, written by the host
	fir_ram #(.data_t(coeff_t)) coeff_ram (
		.clk (clk),
		.wren (coeff_wr.valid),
		.wrptr (coeff_wr.addr),
		.wrdata (coeff_wr.data),
		.rden (rden),
		.rdptr (coeff_rdptr),
		.rddata (coeff_rddata)
	);

	// datapath
	stereo_mac stereo_mac_inst (
		.clk (clk),
		.rstb (rstb),
		.sample (hist_rddata),
		.coeff (coeff_rddata),
		.mac_ctl (mac_ctl),
		.result (aud_out)
	);

endmodule

`default_nettype wire

//--- tb_audio_fir.sv
`default_nettype none

module tb_audio_fir
	import fir_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	//**************************************************
	// run constants
	//**************************************************

	localparam int NSETS = 4;
	localparam int NROWS = 52;
	localparam int MAX_STALL = 8;
	// per row taps, latency, worst stall and handshakes
	localparam int TIMEOUT_CYCLES = NROWS * (FIR_TAPS + 3 + MAX_STALL + 2) + FIR_TAPS * 4 + 200;
	localparam longint OUT_MAX = 32767;
	localparam longint OUT_MIN = -32768;

	// one stimulus row
	typedef struct packed {
		logic [1:0] set;
		stereo_sample_t din;
		stereo_sample_t dexp;
	} row_t;

	logic clk = 1'b0;
	logic rstb;
	stereo_sample_t aud_in;
	logic aud_in_rts;
	logic aud_in_rtr;
	stereo_sample_t aud_out;
	logic aud_out_rts;
	logic aud_out_rtr;
	coeff_wr_t coeff_wr;

	row_t tbl [NROWS];
	coeff_t coeff_sets [NSETS][FIR_TAPS];
	// model history, index k holds x[n-k]
	int hist_left [FIR_TAPS];
	int hist_right [FIR_TAPS];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int sat_hi = 0;
	int sat_lo = 0;
	integer seed = 32'hef537910;

	// 10 ns clock
	always #5 clk = ~clk;

	audio_fir audio_fir_inst (
		.clk (clk),
		.rstb (rstb),
		.aud_in (aud_in),
		.aud_in_rts (aud_in_rts),
		.aud_in_rtr (aud_in_rtr),
		.aud_out (aud_out),
		.aud_out_rts (aud_out_rts),
		.aud_out_rtr (aud_out_rtr),
		.coeff_wr (coeff_wr)
	);

	//**************************************************
	// checking and reference model
	//**************************************************

	task automatic check_value(input int actual, input int expected, input string what);
		checks++;
		if (actual != expected)
		begin
			errors++;
			$display("ERR %0t: %s, got %0d expected %0d", $time, what, actual, expected);
		end
	endtask

	// sum of coeff[k] * x[n-k], floor shift, clamp
	function automatic logic signed [SAMPLE_W-1:0] model_channel(input int set, input bit left);
		longint sum;
		longint x;
		int k;

		sum = 0;
		for (k = 0; k < FIR_TAPS; k++)
		begin
			x = left ? longint'(hist_left[k]) : longint'(hist_right[k]);
			sum += longint'(coeff_sets[set][k]) * x;
		end
		sum = sum >>> COEFF_FRAC;
		if (sum > OUT_MAX)
		begin
			return 16'sh7fff;
		end
		else if (sum < OUT_MIN)
		begin
			return 16'sh8000;
		end
		return SAMPLE_W'(sum);
	endfunction

	task automatic fill_table();
		int r;
		int k;
		logic signed [31:0] rnd;
		stereo_sample_t din;
		stereo_sample_t dexp;

		// set 0 ramp with both signs, set 1 and 3 random, set 2 four big taps
		for (k = 0; k < FIR_TAPS; k++)
		begin
			coeff_sets[0][k] = coeff_t'((k + 1) * 900 - 14000);
			rnd = $random(seed);
			coeff_sets[1][k] = coeff_t'(rnd % 4096);
			coeff_sets[2][k] = (k < 4) ? 16'sh7fff : 16'sh0000;
			rnd = $random(seed);
			coeff_sets[3][k] = coeff_t'(rnd % 2048);
			hist_left[k] = 0;
			hist_right[k] = 0;
		end
		for (r = 0; r < NROWS; r++)
		begin
			if (r < 8)
			begin
				// left impulse, right silent
				tbl[r].set = 2'd0;
				din.left = (r == 0) ? 16'sh7fff : 16'sh0000;
				din.right = 16'sh0000;
			end
			else if (r < 32 || r >= 44)
			begin
				tbl[r].set = (r < 32) ? 2'd1 : 2'd3;
				rnd = $random(seed);
				din.left = rnd[15:0];
				din.right = rnd[31:16];
			end
			else
			begin
				// full scale with opposite signs, swapped halfway
				tbl[r].set = 2'd2;
				din.left = (r < 38) ? 16'sh7fff : 16'sh8000;
				din.right = (r < 38) ? 16'sh8000 : 16'sh7fff;
			end
			// shift the new sample into model history
			for (k = FIR_TAPS - 1; k > 0; k--)
			begin
				hist_left[k] = hist_left[k-1];
				hist_right[k] = hist_right[k-1];
			end
			hist_left[0] = int'(din.left);
			hist_right[0] = int'(din.right);
			dexp.left = model_channel(int'(tbl[r].set), 1'b1);
			dexp.right = model_channel(int'(tbl[r].set), 1'b0);
			tbl[r].din = din;
			tbl[r].dexp = dexp;
			if (dexp.left == 16'sh7fff || dexp.right == 16'sh7fff)
			begin
				sat_hi++;
			end
			if (dexp.left == 16'sh8000 || dexp.right == 16'sh8000)
			begin
				sat_lo++;
			end
		end
	endtask

	//**************************************************
	// bus tasks, each entered right after a rising edge
	//**************************************************

	task automatic load_coeffs(input int set);
		int k;

		for (k = 0; k < FIR_TAPS; k++)
		begin
			@(posedge clk);
			coeff_wr <= '{valid: 1'b1, addr: FIR_PTR'(k), data: coeff_sets[set][k]};
		end
		@(posedge clk);
		coeff_wr <= '0;
	endtask

	task automatic send_sample(input stereo_sample_t din);
		aud_in <= din;
		aud_in_rts <= 1'b1;
		// transfer on the edge that sees rtr high
		do
		begin
			@(posedge clk);
			check_value(int'(aud_out_rts), 0, "aud_out_rts high before intake");
		end
		while (!aud_in_rtr);
		aud_in_rts <= 1'b0;
	endtask

	task automatic receive_result(input int r);
		int lat;
		int stall;
		int s;
		stereo_sample_t held;

		lat = 0;
		// intake stays closed while computing
		do
		begin
			@(posedge clk);
			lat++;
			check_value(int'(aud_in_rtr), 0, $sformatf("row %0d aud_in_rtr during compute", r));
		end
		while (!aud_out_rts);
		// rts rose on the edge before this one
		check_value(lat - 1, FIR_TAPS + 3, $sformatf("row %0d output latency", r));
		held = aud_out;
		stall = $unsigned($random(seed)) % (MAX_STALL + 1);
		// sink back-pressure
		for (s = 0; s < stall; s++)
		begin
			@(posedge clk);
			check_value(int'(aud_out_rts), 1, $sformatf("row %0d rts dropped in stall", r));
			check_value(int'(aud_in_rtr), 0, $sformatf("row %0d rtr high in stall", r));
			check_value(int'(aud_out), int'(held), $sformatf("row %0d aud_out moved", r));
		end
		aud_out_rtr <= 1'b1;
		@(posedge clk);
		// transfer edge
		check_value(int'(aud_out_rts), 1, $sformatf("row %0d rts at transfer", r));
		check_value(int'(aud_out.left), int'(tbl[r].dexp.left), $sformatf("row %0d left", r));
		check_value(int'(aud_out.right), int'(tbl[r].dexp.right), $sformatf("row %0d right", r));
		aud_out_rtr <= 1'b0;
	endtask

	//**************************************************
	// main sequence
	//**************************************************

	initial
	begin
		int r;
		int loaded_set;

		rstb = 1'b0;
		aud_in = '0;
		aud_in_rts = 1'b0;
		aud_out_rtr = 1'b0;
		coeff_wr = '0;
		loaded_set = -1;
		fill_table();
		if (sat_hi == 0 || sat_lo == 0)
		begin
			errors++;
			$display("stimulus table does not reach both clamp limits");
		end
		// reset for 3 cycles
		repeat (3)
		begin
			@(posedge clk);
			check_value(int'(aud_in_rtr), 0, "aud_in_rtr in reset");
			check_value(int'(aud_out_rts), 0, "aud_out_rts in reset");
		end
		rstb <= 1'b1;
		// intake closed during history clear
		repeat (FIR_TAPS)
		begin
			@(posedge clk);
			check_value(int'(aud_in_rtr), 0, "aud_in_rtr during history clear");
			check_value(int'(aud_out_rts), 0, "aud_out_rts during history clear");
		end
		for (r = 0; r < NROWS; r++)
		begin
			// reload only between samples
			if (int'(tbl[r].set) != loaded_set)
			begin
				loaded_set = int'(tbl[r].set);
				load_coeffs(loaded_set);
			end
			send_sample(tbl[r].din);
			receive_result(r);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// watchdog
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("simulation timed out after %0d cycles, %0d errors", cycles, errors);
			$display("Simulation FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- audio_fir.f
fir_pkg.sv
fir_ram.sv
filter_stm.sv
stereo_mac.sv
audio_fir.sv
tb_audio_fir.sv

//--- Makefile
TOP = tb_audio_fir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f audio_fir.f --top-module $(TOP)

sim:
	verilator --binary --timing -f audio_fir.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
